//--- bus_pkg.sv
package bus_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int narrow_data_w = 32;  // master side
  localparam int wide_data_w   = 128; // memory controller side
  localparam int lane_count    = wide_data_w / narrow_data_w;
  localparam int addr_w        = 32;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef logic [$clog2(lane_count)-1:0] lane_t;

  // byte address split into wide line, narrow lane and byte offset
  typedef struct packed {
    logic [addr_w-$bits(lane_t)-3:0] line;
    lane_t                           lane;     // bits 3:2
    logic [1:0]                      byte_ofs; // bits 1:0
  } addr_fields_t;

  typedef union packed {
    logic [addr_w-1:0] raw;
    addr_fields_t      f;
  } axi_addr_u;

endpackage

//--- reset_pkg.sv
package reset_pkg;

  // reset release order, memory side first
  typedef enum logic [1:0] {
    wait_lock,  // clock source not locked
    lock_count, // locked, waiting for it to settle
    mem_init,   // memory out of reset, waiting on its own lock
    run
  } rst_state_t;

  localparam int lock_count_w_default = 8; // top bit set after 128 cycles

endpackage

//--- narrow_bus_if.sv
`timescale 1ns/1ps

interface narrow_bus_if import bus_pkg::*; ();

  // write address
  logic [addr_w-1:0]          awaddr;
  logic                       awvalid;
  logic                       awready;
  // write data
  logic [narrow_data_w-1:0]   wdata;
  logic [narrow_data_w/8-1:0] wstrb;
  logic                       wvalid;
  logic                       wready;
  // write response
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  // read address
  logic [addr_w-1:0]          araddr;
  logic                       arvalid;
  logic                       arready;
  // read data
  logic [narrow_data_w-1:0]   rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;

  modport initiator (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport wr_target (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );

  modport rd_target (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );

endinterface

//--- lane_fifo.sv
`timescale 1ns/1ps

module lane_fifo #(
  parameter int lane_fifo_aw = 1,
  parameter int fifo_dw      = 2
) (
  input  logic               sys_clk,
  input  logic               rstn,
  input  logic               push,
  input  logic [fifo_dw-1:0] push_data,
  input  logic               pop,
  output logic [fifo_dw-1:0] head,
  output logic               full,
  output logic               empty
);
  localparam logic [lane_fifo_aw:0] depth = 1 << lane_fifo_aw;

  logic [fifo_dw-1:0]      mem [depth];
  logic [lane_fifo_aw-1:0] wr_ptr;
  logic [lane_fifo_aw-1:0] rd_ptr;
  logic [lane_fifo_aw:0]   cnt;
  logic [lane_fifo_aw:0]   cnt_nxt;

  always_comb begin
    cnt_nxt = cnt;
    if (push && !pop) begin
      cnt_nxt = cnt + 1'b1;
    end else if (pop && !push) begin
      cnt_nxt = cnt - 1'b1;
    end
  end

  always_ff @(posedge sys_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
      full   <= 1'b1; // blocks new addresses until out of reset
      empty  <= 1'b1;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      cnt   <= cnt_nxt;
      full  <= (cnt_nxt == depth);
      empty <= (cnt_nxt == '0);
    end
  end

  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign head = mem[rd_ptr]; // lane of oldest accepted address

endmodule

//--- lock_timer.sv
`timescale 1ns/1ps

module lock_timer import reset_pkg::*; #(
  parameter int lock_count_w = lock_count_w_default
) (
  input  logic sys_clk,
  input  logic sys_rstn,
  input  logic run,
  output logic expired
);
  logic [lock_count_w-1:0] lock_cnt;

  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      lock_cnt <= '0;
    end else if (!run) begin
      lock_cnt <= '0;                // lock lost, start over
    end else if (lock_cnt != '1) begin
      lock_cnt <= lock_cnt + 1'b1;   // stops at all ones
    end
  end

  assign expired = lock_cnt[lock_count_w-1];

endmodule

//--- reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer import reset_pkg::*; #(
  parameter int lock_count_w = lock_count_w_default
) (
  input  logic sys_clk,
  input  logic sys_rstn,
  input  logic pll_locked,
  input  logic mem_locked,
  input  logic mem_sync_rst,
  output logic mem_rstn,
  output logic ui_rstn
);
  rst_state_t state;
  rst_state_t state_nxt;
  logic       timer_run;
  logic       timer_expired;

  assign timer_run = (state == lock_count);

  lock_timer #(
    .lock_count_w (lock_count_w)
  ) u_lock_timer (
    .sys_clk  (sys_clk),
    .sys_rstn (sys_rstn),
    .run      (timer_run),
    .expired  (timer_expired)
  );

  always_comb begin
    state_nxt = state;
    if (!pll_locked) begin
      state_nxt = wait_lock; // clock loss overrides everything
    end else begin
      case (state)
        wait_lock: state_nxt = lock_count;
        lock_count: begin
          if (timer_expired) begin
            state_nxt = mem_init;
          end
        end
        mem_init: begin
          if (mem_locked && !mem_sync_rst) begin
            state_nxt = run;
          end
        end
        run: begin
          if (mem_sync_rst || !mem_locked) begin
            state_nxt = mem_init; // memory side reset again
          end
        end
        default: state_nxt = wait_lock;
      endcase
    end
  end

  // outputs registered from the next state
  always_ff @(posedge sys_clk or negedge sys_rstn) begin
    if (!sys_rstn) begin
      state    <= wait_lock;
      mem_rstn <= 1'b0;
      ui_rstn  <= 1'b0;
    end else begin
      state    <= state_nxt;
      mem_rstn <= (state_nxt == mem_init) || (state_nxt == run);
      ui_rstn  <= (state_nxt == run);
    end
  end

endmodule

//--- master_select.sv
`timescale 1ns/1ps

module master_select import bus_pkg::*; (
  input logic             sel,   // 0 picks m1, 1 picks m2
  narrow_bus_if.wr_target m1_wr,
  narrow_bus_if.rd_target m1_rd,
  narrow_bus_if.wr_target m2_wr,
  narrow_bus_if.rd_target m2_rd,
  narrow_bus_if.initiator shared
);

  // --------------------------------------------------
  // requests from the selected master
  // --------------------------------------------------
  assign shared.awaddr  = sel ? m2_wr.awaddr  : m1_wr.awaddr;
  assign shared.awvalid = sel ? m2_wr.awvalid : m1_wr.awvalid;
  assign shared.wdata   = sel ? m2_wr.wdata   : m1_wr.wdata;
  assign shared.wstrb   = sel ? m2_wr.wstrb   : m1_wr.wstrb;
  assign shared.wvalid  = sel ? m2_wr.wvalid  : m1_wr.wvalid;
  assign shared.bready  = sel ? m2_wr.bready  : m1_wr.bready;
  assign shared.araddr  = sel ? m2_rd.araddr  : m1_rd.araddr;
  assign shared.arvalid = sel ? m2_rd.arvalid : m1_rd.arvalid;
  assign shared.rready  = sel ? m2_rd.rready  : m1_rd.rready;

  // --------------------------------------------------
  // readies and responses, idle master sees nothing
  // --------------------------------------------------
  assign m1_wr.awready = sel ? 1'b0 : shared.awready;
  assign m2_wr.awready = sel ? shared.awready : 1'b0;
  assign m1_wr.wready  = sel ? 1'b0 : shared.wready;
  assign m2_wr.wready  = sel ? shared.wready : 1'b0;
  assign m1_wr.bvalid  = sel ? 1'b0 : shared.bvalid;
  assign m2_wr.bvalid  = sel ? shared.bvalid : 1'b0;
  assign m1_wr.bresp   = sel ? resp_okay : shared.bresp;
  assign m2_wr.bresp   = sel ? shared.bresp : resp_okay;

  assign m1_rd.arready = sel ? 1'b0 : shared.arready;
  assign m2_rd.arready = sel ? shared.arready : 1'b0;
  assign m1_rd.rvalid  = sel ? 1'b0 : shared.rvalid;
  assign m2_rd.rvalid  = sel ? shared.rvalid : 1'b0;
  assign m1_rd.rresp   = sel ? resp_okay : shared.rresp;
  assign m2_rd.rresp   = sel ? shared.rresp : resp_okay;
  assign m1_rd.rdata   = sel ? '0 : shared.rdata;
  assign m2_rd.rdata   = sel ? shared.rdata : '0;

endmodule

//--- write_lane_packer.sv
`timescale 1ns/1ps

module write_lane_packer import bus_pkg::*; #(
  parameter int lane_fifo_aw = 1
) (
  input  logic                     sys_clk,
  input  logic                     ui_rstn,
  narrow_bus_if.wr_target          bus,
  output logic [addr_w-1:0]        mem_awaddr,
  output logic                     mem_awvalid,
  input  logic                     mem_awready,
  output logic [wide_data_w-1:0]   mem_wdata,
  output logic [wide_data_w/8-1:0] mem_wstrb,
  output logic                     mem_wvalid,
  input  logic                     mem_wready,
  input  logic [1:0]               mem_bresp,
  input  logic                     mem_bvalid,
  output logic                     mem_bready
);
  localparam int strb_w = narrow_data_w / 8;

  axi_addr_u aw_addr;
  axi_addr_u aw_line;
  lane_t     wr_lane;
  logic      lane_full;
  logic      lane_empty;
  logic      aw_ready;
  logic      w_ready;

  // --------------------------------------------------
  // write address
  // --------------------------------------------------
  assign aw_addr.raw = bus.awaddr;

  always_comb begin
    aw_line            = aw_addr;
    aw_line.f.lane     = '0;   // align to the wide line
    aw_line.f.byte_ofs = '0;
  end

  assign aw_ready    = mem_awready && !lane_full;
  assign bus.awready = aw_ready;
  assign mem_awvalid = bus.awvalid && aw_ready;
  assign mem_awaddr  = aw_line.raw;

  lane_fifo #(
    .lane_fifo_aw (lane_fifo_aw),
    .fifo_dw      ($bits(lane_t))
  ) u_wr_lane_fifo (
    .sys_clk   (sys_clk),
    .rstn      (ui_rstn),
    .push      (bus.awvalid && aw_ready),
    .push_data (aw_addr.f.lane),
    .pop       (bus.wvalid && w_ready),
    .head      (wr_lane),
    .full      (lane_full),
    .empty     (lane_empty)
  );

  // --------------------------------------------------
  // write data, needs an address in the fifo first
  // --------------------------------------------------
  assign w_ready    = mem_wready && !lane_empty;
  assign bus.wready = w_ready;
  assign mem_wvalid = bus.wvalid && w_ready;
  assign mem_wdata  = {lane_count{bus.wdata}}; // same word in every lane

  always_comb begin
    mem_wstrb                            = '0;
    mem_wstrb[wr_lane*strb_w +: strb_w]  = bus.wstrb;
  end

  // write response goes straight back
  assign bus.bresp  = mem_bresp;
  assign bus.bvalid = mem_bvalid;
  assign mem_bready = bus.bready;

endmodule

//--- read_lane_selector.sv
`timescale 1ns/1ps

module read_lane_selector import bus_pkg::*; #(
  parameter int lane_fifo_aw = 1
) (
  input  logic                   sys_clk,
  input  logic                   ui_rstn,
  narrow_bus_if.rd_target        bus,
  output logic [addr_w-1:0]      mem_araddr,
  output logic                   mem_arvalid,
  input  logic                   mem_arready,
  input  logic [wide_data_w-1:0] mem_rdata,
  input  logic [1:0]             mem_rresp,
  input  logic                   mem_rvalid,
  output logic                   mem_rready
);
  axi_addr_u ar_addr;
  axi_addr_u ar_line;
  lane_t     rd_lane;
  logic      lane_full;
  logic      lane_empty;
  logic      ar_ready;

  assign ar_addr.raw = bus.araddr;

  always_comb begin
    ar_line            = ar_addr;
    ar_line.f.lane     = '0;
    ar_line.f.byte_ofs = '0;
  end

  assign ar_ready    = mem_arready && !lane_full; // room to record the lane
  assign bus.arready = ar_ready;
  assign mem_arvalid = bus.arvalid && ar_ready;
  assign mem_araddr  = ar_line.raw;

  lane_fifo #(
    .lane_fifo_aw (lane_fifo_aw),
    .fifo_dw      ($bits(lane_t))
  ) u_rd_lane_fifo (
    .sys_clk   (sys_clk),
    .rstn      (ui_rstn),
    .push      (bus.arvalid && ar_ready),
    .push_data (ar_addr.f.lane),
    .pop       (mem_rvalid && bus.rready && !lane_empty),
    .head      (rd_lane),
    .full      (lane_full),
    .empty     (lane_empty)
  );

  // narrow slice of the wide beat, lane from the oldest read
  assign bus.rdata  = mem_rdata[rd_lane*narrow_data_w +: narrow_data_w];
  assign bus.rresp  = mem_rresp;
  assign bus.rvalid = mem_rvalid;
  assign mem_rready = bus.rready;

endmodule

//--- ddr_bridge_top.sv
`timescale 1ns/1ps

module ddr_bridge_top import bus_pkg::*; import reset_pkg::*; #(
  parameter int lock_count_w = lock_count_w_default,
  parameter int lane_fifo_aw = 1
) (
  input  logic                       sys_clk,
  input  logic                       sys_rstn,
  input  logic                       master_sel,
  input  logic                       pll_locked, mem_locked, mem_sync_rst,
  output logic                       mem_rstn, ui_rstn,
  // master 1
  input  logic [addr_w-1:0]          m1_awaddr, m1_araddr,
  input  logic [narrow_data_w-1:0]   m1_wdata,
  input  logic [narrow_data_w/8-1:0] m1_wstrb,
  input  logic                       m1_awvalid, m1_wvalid, m1_bready, m1_arvalid, m1_rready,
  output logic                       m1_awready, m1_wready, m1_bvalid, m1_arready, m1_rvalid,
  output logic [1:0]                 m1_bresp, m1_rresp,
  output logic [narrow_data_w-1:0]   m1_rdata,
  // master 2
  input  logic [addr_w-1:0]          m2_awaddr, m2_araddr,
  input  logic [narrow_data_w-1:0]   m2_wdata,
  input  logic [narrow_data_w/8-1:0] m2_wstrb,
  input  logic                       m2_awvalid, m2_wvalid, m2_bready, m2_arvalid, m2_rready,
  output logic                       m2_awready, m2_wready, m2_bvalid, m2_arready, m2_rvalid,
  output logic [1:0]                 m2_bresp, m2_rresp,
  output logic [narrow_data_w-1:0]   m2_rdata,
  // memory controller port
  output logic [addr_w-1:0]          mem_awaddr, mem_araddr,
  output logic [wide_data_w-1:0]     mem_wdata,
  output logic [wide_data_w/8-1:0]   mem_wstrb,
  output logic                       mem_awvalid, mem_wvalid, mem_bready, mem_arvalid,
  output logic                       mem_rready,
  input  logic                       mem_awready, mem_wready, mem_bvalid, mem_arready,
  input  logic                       mem_rvalid,
  input  logic [1:0]                 mem_bresp, mem_rresp,
  input  logic [wide_data_w-1:0]     mem_rdata
);
  narrow_bus_if m1_bus ();
  narrow_bus_if m2_bus ();
  narrow_bus_if shared_bus ();

  // --------------------------------------------------
  // master ports onto their bus instances
  // --------------------------------------------------
  assign m1_bus.awaddr  = m1_awaddr;
  assign m1_bus.awvalid = m1_awvalid;
  assign m1_bus.wdata   = m1_wdata;
  assign m1_bus.wstrb   = m1_wstrb;
  assign m1_bus.wvalid  = m1_wvalid;
  assign m1_bus.bready  = m1_bready;
  assign m1_bus.araddr  = m1_araddr;
  assign m1_bus.arvalid = m1_arvalid;
  assign m1_bus.rready  = m1_rready;
  assign m1_awready     = m1_bus.awready;
  assign m1_wready      = m1_bus.wready;
  assign m1_bresp       = m1_bus.bresp;
  assign m1_bvalid      = m1_bus.bvalid;
  assign m1_arready     = m1_bus.arready;
  assign m1_rdata       = m1_bus.rdata;
  assign m1_rresp       = m1_bus.rresp;
  assign m1_rvalid      = m1_bus.rvalid;

  assign m2_bus.awaddr  = m2_awaddr;
  assign m2_bus.awvalid = m2_awvalid;
  assign m2_bus.wdata   = m2_wdata;
  assign m2_bus.wstrb   = m2_wstrb;
  assign m2_bus.wvalid  = m2_wvalid;
  assign m2_bus.bready  = m2_bready;
  assign m2_bus.araddr  = m2_araddr;
  assign m2_bus.arvalid = m2_arvalid;
  assign m2_bus.rready  = m2_rready;
  assign m2_awready     = m2_bus.awready;
  assign m2_wready      = m2_bus.wready;
  assign m2_bresp       = m2_bus.bresp;
  assign m2_bvalid      = m2_bus.bvalid;
  assign m2_arready     = m2_bus.arready;
  assign m2_rdata       = m2_bus.rdata;
  assign m2_rresp       = m2_bus.rresp;
  assign m2_rvalid      = m2_bus.rvalid;

  // --------------------------------------------------
  // blocks
  // --------------------------------------------------
  reset_sequencer #(
    .lock_count_w (lock_count_w)
  ) u_reset_sequencer (
    .sys_clk      (sys_clk),
    .sys_rstn     (sys_rstn),
    .pll_locked   (pll_locked),
    .mem_locked   (mem_locked),
    .mem_sync_rst (mem_sync_rst),
    .mem_rstn     (mem_rstn),
    .ui_rstn      (ui_rstn)
  );

  master_select u_master_select (
    .sel    (master_sel),
    .m1_wr  (m1_bus),
    .m1_rd  (m1_bus),
    .m2_wr  (m2_bus),
    .m2_rd  (m2_bus),
    .shared (shared_bus)
  );

  write_lane_packer #(
    .lane_fifo_aw (lane_fifo_aw)
  ) u_write_lane_packer (
    .sys_clk     (sys_clk),
    .ui_rstn     (ui_rstn),
    .bus         (shared_bus),
    .mem_awaddr  (mem_awaddr),
    .mem_awvalid (mem_awvalid),
    .mem_awready (mem_awready),
    .mem_wdata   (mem_wdata),
    .mem_wstrb   (mem_wstrb),
    .mem_wvalid  (mem_wvalid),
    .mem_wready  (mem_wready),
    .mem_bresp   (mem_bresp),
    .mem_bvalid  (mem_bvalid),
    .mem_bready  (mem_bready)
  );

  read_lane_selector #(
    .lane_fifo_aw (lane_fifo_aw)
  ) u_read_lane_selector (
    .sys_clk     (sys_clk),
    .ui_rstn     (ui_rstn),
    .bus         (shared_bus),
    .mem_araddr  (mem_araddr),
    .mem_arvalid (mem_arvalid),
    .mem_arready (mem_arready),
    .mem_rdata   (mem_rdata),
    .mem_rresp   (mem_rresp),
    .mem_rvalid  (mem_rvalid),
    .mem_rready  (mem_rready)
  );

endmodule

//--- tb_ddr_bridge.sv
`timescale 1ns/1ps

module tb_ddr_bridge import bus_pkg::*; ();

  localparam int num_transfers   = 54; // 18 rounds of one write and two reads
  localparam int watchdog_cycles = 8 + 132 + num_transfers * 40;

  logic sys_clk = 1'b0;
  logic sys_rstn, master_sel, pll_locked, mem_locked, mem_sync_rst;
  wire  mem_rstn, ui_rstn;

  // index 0 is m1, index 1 is m2
  logic [1:0][addr_w-1:0]          m_awaddr, m_araddr;
  logic [1:0][narrow_data_w-1:0]   m_wdata;
  logic [1:0][narrow_data_w/8-1:0] m_wstrb;
  logic [1:0]                      m_awvalid, m_wvalid, m_bready, m_arvalid, m_rready;
  wire  [1:0]                      m_awready, m_wready, m_bvalid, m_arready, m_rvalid;
  wire  [1:0][1:0]                 m_bresp, m_rresp;
  wire  [1:0][narrow_data_w-1:0]   m_rdata;

  wire  [addr_w-1:0]        mem_awaddr, mem_araddr;
  wire  [wide_data_w-1:0]   mem_wdata;
  wire  [wide_data_w/8-1:0] mem_wstrb;
  wire                      mem_awvalid, mem_wvalid, mem_bready, mem_arvalid, mem_rready;
  logic                     mem_awready, mem_wready, mem_bvalid, mem_arready, mem_rvalid;
  logic [1:0]               mem_bresp, mem_rresp;
  logic [wide_data_w-1:0]   mem_rdata;

  // expected values, set by the master tasks
  logic [addr_w-1:0]        exp_awaddr;
  logic [wide_data_w-1:0]   exp_wdata;
  logic [wide_data_w/8-1:0] exp_wstrb;
  logic [narrow_data_w-1:0] exp_rdata;
  logic [narrow_data_w-1:0] exp_rd_q [$];
  int                       aw_cnt = 0;
  int                       w_cnt = 0;
  int                       lock_cycles = -1; // edges since pll_locked first seen high

  always #4 sys_clk = ~sys_clk;

  ddr_bridge_top dut0 (
    .m1_awaddr  (m_awaddr[0]),  .m2_awaddr  (m_awaddr[1]),
    .m1_awvalid (m_awvalid[0]), .m2_awvalid (m_awvalid[1]),
    .m1_awready (m_awready[0]), .m2_awready (m_awready[1]),
    .m1_wdata   (m_wdata[0]),   .m2_wdata   (m_wdata[1]),
    .m1_wstrb   (m_wstrb[0]),   .m2_wstrb   (m_wstrb[1]),
    .m1_wvalid  (m_wvalid[0]),  .m2_wvalid  (m_wvalid[1]),
    .m1_wready  (m_wready[0]),  .m2_wready  (m_wready[1]),
    .m1_bresp   (m_bresp[0]),   .m2_bresp   (m_bresp[1]),
    .m1_bvalid  (m_bvalid[0]),  .m2_bvalid  (m_bvalid[1]),
    .m1_bready  (m_bready[0]),  .m2_bready  (m_bready[1]),
    .m1_araddr  (m_araddr[0]),  .m2_araddr  (m_araddr[1]),
    .m1_arvalid (m_arvalid[0]), .m2_arvalid (m_arvalid[1]),
    .m1_arready (m_arready[0]), .m2_arready (m_arready[1]),
    .m1_rdata   (m_rdata[0]),   .m2_rdata   (m_rdata[1]),
    .m1_rresp   (m_rresp[0]),   .m2_rresp   (m_rresp[1]),
    .m1_rvalid  (m_rvalid[0]),  .m2_rvalid  (m_rvalid[1]),
    .m1_rready  (m_rready[0]),  .m2_rready  (m_rready[1]),
    .*
  );

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got, exp);
    stop_with_error($sformatf("Mismatch at %0t ns: %s is %0h, expected %0h",
                              $time, name, got, exp));
  endtask

  // --------------------------------------------------
  // reference data
  // --------------------------------------------------
  function automatic logic [wide_data_w-1:0] fill_word(input logic [addr_w-1:0] a);
    return {a ^ 32'h5a5a_0f0f, ~a, {a[15:0], a[31:16]}, a + 32'h0123_4567};
  endfunction

  function automatic logic [narrow_data_w-1:0] fill_lane(input logic [addr_w-1:0] a);
    logic [wide_data_w-1:0] w;
    w = fill_word({a[addr_w-1:4], 4'h0});
    return w[a[3:2]*narrow_data_w +: narrow_data_w];
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  // --------------------------------------------------
  // wide memory model
  // --------------------------------------------------
  logic [wide_data_w-1:0] mem_words [logic [addr_w-1:0]];
  logic [addr_w-1:0]      aw_q [$];
  logic [addr_w-1:0]      ar_q [$];
  int                     pending_b = 0;
  bit                     b_fire, r_fire;

  function automatic logic [wide_data_w-1:0] model_word(input logic [addr_w-1:0] a);
    return mem_words.exists(a) ? mem_words[a] : fill_word(a);
  endfunction

  always @(posedge sys_clk) begin
    logic [wide_data_w-1:0] word;
    logic [addr_w-1:0]      a;
    if (mem_wvalid && mem_wready) begin // beat belongs to the oldest address
      a    = aw_q.pop_front();
      word = model_word(a);
      for (int i = 0; i < wide_data_w / 8; i++) begin
        if (mem_wstrb[i]) word[8*i +: 8] = mem_wdata[8*i +: 8];
      end
      mem_words[a] = word;
      pending_b++;
    end
    if (mem_awvalid && mem_awready) aw_q.push_back(mem_awaddr);
    if (mem_arvalid && mem_arready) ar_q.push_back(mem_araddr);
    b_fire = mem_bvalid && mem_bready;
    r_fire = mem_rvalid && mem_rready;
    if (b_fire) pending_b--;
    if (r_fire) void'(ar_q.pop_front());
  end

  always @(negedge sys_clk) begin
    {mem_awready, mem_wready, mem_arready} = $urandom;
    {m_bready, m_rready} = $urandom;
    if (!mem_bvalid || b_fire) begin // hold a response until taken
      mem_bvalid = (pending_b > 0) && ($urandom_range(1) == 1);
      mem_bresp  = $urandom; // random code to pass through
    end
    if (!mem_rvalid || r_fire) begin
      mem_rvalid = (ar_q.size() > 0) && ($urandom_range(2) == 0);
      mem_rresp  = $urandom;
      if (mem_rvalid) mem_rdata = model_word(ar_q[0]);
    end
  end

  // handshake bookkeeping
  always @(posedge sys_clk) begin
    lock_cycles <= pll_locked ? lock_cycles + 1 : -1;
    if (|(m_awvalid & m_awready)) aw_cnt <= aw_cnt + 1;
    if (|(m_wvalid & m_wready)) w_cnt <= w_cnt + 1;
    if (|(m_rvalid & m_rready)) void'(exp_rd_q.pop_front());
  end

  always @(negedge sys_clk) begin
    if (exp_rd_q.size() > 0) exp_rdata = exp_rd_q[0];
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  assert property (@(posedge sys_clk) !sys_rstn |-> !mem_rstn && !ui_rstn)
    else stop_with_error("memory or user reset released while sys_rstn was low");
  assert property (@(posedge sys_clk) $rose(mem_rstn) |-> lock_cycles inside {[128:132]})
    else stop_with_error($sformatf("mem_rstn released %0d cycles after lock", lock_cycles));
  assert property (@(posedge sys_clk)
                   pll_locked && mem_rstn && mem_locked && !mem_sync_rst |-> ##[0:2] ui_rstn)
    else stop_with_error("ui_rstn not released after the memory reported ready");
  assert property (@(posedge sys_clk) mem_sync_rst || !mem_locked |-> ##[1:2] !ui_rstn)
    else stop_with_error("ui_rstn still high after a memory side reset");
  assert property (@(posedge sys_clk) !ui_rstn |-> (m_awready | m_wready | m_arready) == '0)
    else stop_with_error("master ready seen while ui_rstn was low");
  assert property (@(posedge sys_clk) mem_awvalid && mem_awready |-> mem_awaddr == exp_awaddr)
    else report_mismatch("mem_awaddr", $sampled(mem_awaddr), exp_awaddr);
  assert property (@(posedge sys_clk) mem_wvalid && mem_wready |-> mem_wdata == exp_wdata)
    else report_mismatch("mem_wdata", $sampled(mem_wdata), exp_wdata);
  assert property (@(posedge sys_clk) mem_wvalid && mem_wready |-> mem_wstrb == exp_wstrb)
    else report_mismatch("mem_wstrb", $sampled(mem_wstrb), exp_wstrb);
  assert property (@(posedge sys_clk) |(m_rvalid & m_rready) |->
                   m_rdata[master_sel] == exp_rdata)
    else report_mismatch("m_rdata", $sampled(m_rdata[master_sel]), exp_rdata);
  assert property (@(posedge sys_clk) m_bvalid[master_sel] |->
                   m_bresp[master_sel] == mem_bresp)
    else report_mismatch("m_bresp", $sampled(m_bresp[master_sel]), $sampled(mem_bresp));
  assert property (@(posedge sys_clk) m_rvalid[master_sel] |->
                   m_rresp[master_sel] == mem_rresp)
    else report_mismatch("m_rresp", $sampled(m_rresp[master_sel]), $sampled(mem_rresp));
  assert property (@(posedge sys_clk) mem_bready == m_bready[master_sel])
    else report_mismatch("mem_bready", $sampled(mem_bready),
                         $sampled(m_bready[master_sel]));
  assert property (@(posedge sys_clk) mem_rready == m_rready[master_sel])
    else report_mismatch("mem_rready", $sampled(mem_rready),
                         $sampled(m_rready[master_sel]));
  assert property (@(posedge sys_clk) !master_sel |->
                   !(m_awready[1] || m_wready[1] || m_arready[1] || m_bvalid[1] || m_rvalid[1])
                   && m_bresp[1] == '0 && m_rresp[1] == '0 && m_rdata[1] == '0)
    else stop_with_error("m2 saw a ready or response while m1 was selected");
  assert property (@(posedge sys_clk) master_sel |->
                   !(m_awready[0] || m_wready[0] || m_arready[0] || m_bvalid[0] || m_rvalid[0])
                   && m_bresp[0] == '0 && m_rresp[0] == '0 && m_rdata[0] == '0)
    else stop_with_error("m1 saw a ready or response while m2 was selected");
  assert property (@(posedge sys_clk) |m_awready |-> mem_awready)
    else stop_with_error("awready given to a master while mem_awready was low");
  assert property (@(posedge sys_clk) |m_arready |-> mem_arready)
    else stop_with_error("arready given to a master while mem_arready was low");
  assert property (@(posedge sys_clk) |m_wready |-> aw_cnt > w_cnt)
    else stop_with_error("wready given before the write address was accepted");

  // --------------------------------------------------
  // master tasks, all start and end on a falling edge
  // --------------------------------------------------
  task automatic do_write(input int m, input logic [31:0] addr, data, input logic [3:0] strb);
    bit aw_done;
    bit w_done;
    aw_done    = 1'b0;
    w_done     = 1'b0;
    exp_awaddr = {addr[31:4], 4'h0};
    exp_wdata  = {lane_count{data}};
    exp_wstrb  = {12'h0, strb} << (4 * addr[3:2]);
    m_awaddr[m]  = addr;
    m_wdata[m]   = data;
    m_wstrb[m]   = strb;
    m_awvalid[m] = 1'b1;
    m_wvalid[m]  = 1'b1; // beat offered together with its address
    while (!(aw_done && w_done)) begin
      @(posedge sys_clk);
      if (m_awvalid[m] && m_awready[m]) aw_done = 1'b1;
      if (m_wvalid[m] && m_wready[m]) w_done = 1'b1;
      @(negedge sys_clk);
      m_awvalid[m] = !aw_done;
      m_wvalid[m]  = !w_done;
    end
    do @(posedge sys_clk); while (!(m_bvalid[m] && m_bready[m]));
    @(negedge sys_clk);
  endtask

  task automatic issue_read(input int m, input logic [31:0] addr, exp);
    exp_rd_q.push_back(exp);
    m_araddr[m]  = addr;
    m_arvalid[m] = 1'b1;
    do @(posedge sys_clk); while (!m_arready[m]);
    @(negedge sys_clk);
    m_arvalid[m] = 1'b0;
  endtask

  task automatic run_master(input int m, input logic [31:0] wr_base, input int rounds);
    logic [31:0] addr, raddr, data;
    logic [3:0]  strb;
    for (int i = 0; i < rounds; i++) begin
      addr  = wr_base + i * 16 + ($urandom & 15); // random lane and byte offset
      raddr = 32'h2000_0000 | ($urandom & 32'h000f_ffff); // never written
      data  = $urandom;
      strb  = $urandom;
      do_write(m, addr, data, strb);
      issue_read(m, addr, merge_bytes(fill_lane(addr), data, strb));
      issue_read(m, raddr, fill_lane(raddr)); // second read in flight
      while (exp_rd_q.size() != 0) @(negedge sys_clk);
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge sys_clk);
    stop_with_error($sformatf("Timeout, run still busy after %0d cycles", watchdog_cycles));
  end

  initial begin
    void'($urandom(32'h53eb6d9a));
    sys_rstn     = 1'b0;
    master_sel   = 1'b0;
    pll_locked   = 1'b0;
    mem_locked   = 1'b0;
    mem_sync_rst = 1'b0;
    m_awaddr     = '0;
    m_araddr     = '0;
    m_wdata      = '0;
    m_wstrb      = '0;
    m_awvalid    = '0;
    m_wvalid     = '0;
    m_bready     = '0;
    m_arvalid    = '0;
    m_rready     = '0;
    mem_awready  = 1'b0;
    mem_wready   = 1'b0;
    mem_arready  = 1'b0;
    mem_bvalid   = 1'b0;
    mem_rvalid   = 1'b0;
    mem_bresp    = resp_okay;
    mem_rresp    = resp_okay;
    mem_rdata    = '0;
    repeat (8) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rstn = 1'b1;
    repeat (3) @(negedge sys_clk);
    pll_locked = 1'b1;
    while (!mem_rstn) @(negedge sys_clk);
    repeat (5) @(negedge sys_clk);
    mem_locked = 1'b1; // memory calibrated
    while (!ui_rstn) @(negedge sys_clk);

    run_master(0, 32'h1000_0000, 8);
    master_sel = 1'b1; // both masters idle here
    run_master(1, 32'h1800_0000, 8);

    mem_sync_rst = 1'b1;
    repeat (4) @(negedge sys_clk);
    mem_sync_rst = 1'b0;
    while (!ui_rstn) @(negedge sys_clk);
    run_master(1, 32'h1800_1000, 2);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- filelist.f
bus_pkg.sv
reset_pkg.sv
narrow_bus_if.sv
lane_fifo.sv
lock_timer.sv
reset_sequencer.sv
master_select.sv
write_lane_packer.sv
read_lane_selector.sv
ddr_bridge_top.sv
tb_ddr_bridge.sv
